// ==== common/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

	// one bus write, rs in the top bit
	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_cmd_t;

	// display setup, msb first
	typedef struct packed {
		logic two_lines;
		logic font_5x10;
		logic display_on;
		logic cursor_on;
		logic blink_on;
		logic increment;
		logic shift;
	} lcd_config_t;

	typedef enum logic [1:0] {
		ST_POWER_UP,
		ST_INIT,
		ST_IDLE,
		ST_PULSE
	} drv_state_t;

	typedef enum logic [1:0] {
		FS_IDLE,
		FS_SEND_ADDR,
		FS_SEND_CHAR,
		FS_WAIT
	} fmt_state_t;

	// host control codes
	localparam logic [7:0] CHAR_NEWLINE = 8'h0A;
	localparam logic [7:0] CHAR_CLEAR   = 8'h0C;

	// hd44780 instructions
	localparam logic [7:0] CMD_CLEAR    = 8'h01;
	localparam logic [7:0] CMD_HOME     = 8'h02;
	localparam logic [7:0] CMD_SET_ADDR = 8'h80;
	localparam logic [7:0] LINE2_BASE   = 8'h40; // ddram start of line 2

endpackage

`default_nettype wire

// ==== lcd_driver/lcd_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_driver #(
	parameter int clk_per_us = 2
) (
	input  wire                   clk,
	input  wire                   rst,
	input  wire lcd_pkg::lcd_config_t cfg,
	input  wire lcd_pkg::lcd_cmd_t    cmd,
	input  wire                   cmd_valid,
	output logic                  drv_busy,
	output logic                  e,
	output logic                  rs,
	output logic                  rw,
	output logic [7:0]            lcd_data
);

	localparam int PWR_CYC = 500 * clk_per_us;
	localparam int CW      = $clog2(PWR_CYC + 1);

	// init schedule as cycle offsets from the start of ST_INIT
	localparam int T10  = 10 * clk_per_us;
	localparam int T60  = 60 * clk_per_us;
	localparam int T70  = 70 * clk_per_us;
	localparam int T120 = 120 * clk_per_us;
	localparam int T130 = 130 * clk_per_us;
	localparam int T330 = 330 * clk_per_us;
	localparam int T340 = 340 * clk_per_us;
	localparam int T440 = 440 * clk_per_us;

	// command pulse offsets from the strobe
	localparam int E_RISE     = clk_per_us;
	localparam int E_FALL     = 14 * clk_per_us;
	localparam int HOLD_SHORT = 50 * clk_per_us;
	localparam int HOLD_LONG  = 200 * clk_per_us;

	lcd_pkg::drv_state_t state;
	logic [CW-1:0] cnt;
	logic [CW-1:0] cnt_next;
	logic [CW-1:0] hold_end;
	logic          hold_long; // clear or home in flight

	function automatic logic init_e_at(input logic [CW-1:0] n);
		init_e_at = (n < T10) || (n >= T60 && n < T70) ||
			(n >= T120 && n < T130) || (n >= T330 && n < T340);
	endfunction

	function automatic logic [7:0] init_byte_at(input logic [CW-1:0] n,
			input lcd_pkg::lcd_config_t c);
		logic [7:0] b;
		if (n < T60)
			b = {4'b0011, c.two_lines, c.font_5x10, 2'b00}; // function set
		else if (n < T120)
			b = {5'b00001, c.display_on, c.cursor_on, c.blink_on};
		else if (n < T330)
			b = lcd_pkg::CMD_CLEAR;
		else
			b = {6'b000001, c.increment, c.shift}; // entry mode
		init_byte_at = init_e_at(n) ? b : 8'h00; // bus idles at 0 in gaps
	endfunction

	assign cnt_next = cnt + 1'b1;
	assign hold_end = hold_long ? CW'(HOLD_LONG) : CW'(HOLD_SHORT);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= lcd_pkg::ST_POWER_UP;
			cnt      <= '0;
			drv_busy <= 1'b1;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= 8'h00;
		end else begin
			case (state)
				lcd_pkg::ST_POWER_UP: begin
					if (cnt_next == CW'(PWR_CYC)) begin
						state    <= lcd_pkg::ST_INIT;
						cnt      <= '0;
						e        <= init_e_at('0);
						lcd_data <= init_byte_at('0, cfg);
					end else begin
						cnt <= cnt_next;
					end
				end
				lcd_pkg::ST_INIT: begin
					if (cnt_next == CW'(T440)) begin
						state    <= lcd_pkg::ST_IDLE;
						cnt      <= '0;
						drv_busy <= 1'b0;
						lcd_data <= 8'h00;
					end else begin
						cnt      <= cnt_next;
						e        <= init_e_at(cnt_next);
						lcd_data <= init_byte_at(cnt_next, cfg);
					end
				end
				lcd_pkg::ST_IDLE: begin
					if (cmd_valid) begin
						state     <= lcd_pkg::ST_PULSE;
						cnt       <= '0;
						drv_busy  <= 1'b1;
						rs        <= cmd.rs;
						rw        <= cmd.rw;
						lcd_data  <= cmd.data;
						hold_long <= !cmd.rs && (cmd.data == lcd_pkg::CMD_CLEAR ||
							cmd.data == lcd_pkg::CMD_HOME);
					end
				end
				lcd_pkg::ST_PULSE: begin
					if (cnt_next == hold_end) begin
						state    <= lcd_pkg::ST_IDLE;
						cnt      <= '0;
						drv_busy <= 1'b0;
					end else begin
						cnt <= cnt_next;
						e   <= (cnt_next >= E_RISE) && (cnt_next < E_FALL); // 13 us high
					end
				end
				default: state <= lcd_pkg::ST_POWER_UP;
			endcase
		end
	end

	a_no_e_idle: assert property (@(posedge clk) disable iff (rst)
		(state == lcd_pkg::ST_IDLE) |-> !e)
		else $error("enable high while driver idle");

	// formatter must wait for drv_busy to drop
	a_no_cmd_busy: assert property (@(posedge clk) disable iff (rst)
		cmd_valid |-> !drv_busy)
		else $error("command strobe while driver busy");

endmodule

`default_nettype wire

// ==== source/text_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module text_formatter #(
	parameter int line_length = 16
) (
	input  wire                clk,
	input  wire                rst,
	input  wire [7:0]          char_in,
	input  wire                char_valid,
	output logic               busy,
	input  wire                drv_busy,
	output lcd_pkg::lcd_cmd_t  cmd,
	output logic               cmd_valid
);

	localparam int CW = $clog2(line_length + 1);

	lcd_pkg::fmt_state_t state;
	logic [CW-1:0] col;  // chars written on the current line
	logic          line; // 0 first line, 1 second
	logic [7:0]    pend; // held host character
	logic          sending;

	assign sending   = (state == lcd_pkg::FS_SEND_ADDR) || (state == lcd_pkg::FS_SEND_CHAR);
	assign cmd_valid = sending && !drv_busy; // first free driver cycle
	assign busy      = (state != lcd_pkg::FS_IDLE) || drv_busy; // covers driver init too

	always_comb begin
		cmd.rw = 1'b0; // write only
		if (state == lcd_pkg::FS_SEND_ADDR) begin
			cmd.rs   = 1'b0;
			cmd.data = lcd_pkg::CMD_SET_ADDR | (line ? lcd_pkg::LINE2_BASE : 8'h00);
		end else if (pend == lcd_pkg::CHAR_CLEAR) begin
			cmd.rs   = 1'b0;
			cmd.data = lcd_pkg::CMD_CLEAR;
		end else begin
			cmd.rs   = 1'b1;
			cmd.data = pend;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= lcd_pkg::FS_IDLE;
			col   <= '0;
			line  <= 1'b0;
		end else begin
			case (state)
				lcd_pkg::FS_IDLE: begin
					if (char_valid) begin
						pend <= char_in;
						if (char_in == lcd_pkg::CHAR_CLEAR) begin
							state <= lcd_pkg::FS_SEND_CHAR; // sends CMD_CLEAR
							col   <= '0;
							line  <= 1'b0;
						end else if (char_in == lcd_pkg::CHAR_NEWLINE) begin
							state <= lcd_pkg::FS_SEND_ADDR;
							col   <= '0;
							line  <= !line;
						end else if (col == CW'(line_length)) begin
							state <= lcd_pkg::FS_SEND_ADDR; // line full, move first
							col   <= CW'(1);
							line  <= !line;
						end else begin
							state <= lcd_pkg::FS_SEND_CHAR;
							col   <= col + 1'b1;
						end
					end
				end
				lcd_pkg::FS_SEND_ADDR: begin
					if (!drv_busy) begin
						if (pend == lcd_pkg::CHAR_NEWLINE)
							state <= lcd_pkg::FS_WAIT;
						else
							state <= lcd_pkg::FS_SEND_CHAR;
					end
				end
				lcd_pkg::FS_SEND_CHAR: begin
					if (!drv_busy)
						state <= lcd_pkg::FS_WAIT;
				end
				lcd_pkg::FS_WAIT: begin
					// driver picks up the strobe one cycle late, so drv_busy is already high here
					if (!drv_busy)
						state <= lcd_pkg::FS_IDLE;
				end
				default: state <= lcd_pkg::FS_IDLE;
			endcase
		end
	end

	a_no_char_busy: assert property (@(posedge clk) disable iff (rst)
		char_valid |-> !busy)
		else $error("host character strobe while busy");

endmodule

`default_nettype wire

// ==== source/lcd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_top #(
	parameter int clk_per_us  = 2,
	parameter int line_length = 16
) (
	input  wire                       clk,
	input  wire                       rst,
	input  wire lcd_pkg::lcd_config_t cfg,
	input  wire [7:0]                 char_in,
	input  wire                       char_valid,
	output wire                       busy,
	output wire                       e,
	output wire                       rs,
	output wire                       rw,
	output wire [7:0]                 lcd_data
);

	lcd_pkg::lcd_cmd_t cmd;
	logic              cmd_valid;
	logic              drv_busy;

	// busy already folds in drv_busy
	text_formatter #(
		.line_length(line_length)
	) fmt0 (
		.clk       (clk),
		.rst       (rst),
		.char_in   (char_in),
		.char_valid(char_valid),
		.busy      (busy),
		.drv_busy  (drv_busy),
		.cmd       (cmd),
		.cmd_valid (cmd_valid)
	);

	lcd_driver #(
		.clk_per_us(clk_per_us)
	) drv0 (
		.clk      (clk),
		.rst      (rst),
		.cfg      (cfg),
		.cmd      (cmd),
		.cmd_valid(cmd_valid),
		.drv_busy (drv_busy),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data)
	);

endmodule

`default_nettype wire

// ==== bench/lcd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_tb;

	localparam int T        = 2;
	localparam int PWR      = 500 * T;
	localparam int LIMIT    = 6000; // cycles per busy wait
	localparam int W_INIT   = 10 * T;
	localparam int W_CMD    = 13 * T;

	logic                 clk;
	logic                 rst;
	lcd_pkg::lcd_config_t cfg;
	logic [7:0]           char_in;
	logic                 char_valid;
	wire                  busy;
	wire                  e;
	wire                  rs;
	wire                  rw;
	wire [7:0]            lcd_data;

	lcd_pkg::lcd_cmd_t captures[$];
	int                errors;
	int                tests;
	int                failed_tests;
	int                test_start;
	bit                test_open;
	bit                timed_out;
	reg [8*16-1:0]     name;

	// monitor state
	int cyc;
	int width;
	bit e_q;
	bit init_done;

	lcd_top #(
		.clk_per_us (T),
		.line_length(16)
	) dut0 (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.char_in   (char_in),
		.char_valid(char_valid),
		.busy      (busy),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic check(input string sig, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL time %0t: %s got %h expected %h", $time, sig, got, exp);
			errors++;
		end
	endtask

	// samples registered outputs at the edge, before they update
	always @(posedge clk) begin
		if (rst) begin
			cyc       = 0;
			width     = 0;
			e_q       = 1'b0;
			init_done = 1'b0;
		end else begin
			cyc++;
			if (cyc <= PWR) begin
				check("busy", 32'(busy), 32'd1);
				check("e", 32'(e), 32'd0);
			end
			if (e && !e_q)
				captures.push_back(lcd_pkg::lcd_cmd_t'({rs, rw, lcd_data}));
			if (e)
				width++;
			if (!e && e_q) begin
				check("e width", 32'(width), init_done ? 32'(W_CMD) : 32'(W_INIT));
				width = 0;
			end
			if (!busy)
				init_done = 1'b1;
			e_q = e;
		end
	end

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (busy) begin
			$display("timeout: busy still high after %0d cycles", LIMIT);
			timed_out = 1'b1;
		end
	endtask

	task automatic apply_reset(input logic [6:0] word);
		cfg = lcd_pkg::lcd_config_t'(word);
		rst = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		wait_idle(); // power-up plus init
	endtask

	task automatic send_char(input logic [7:0] c);
		wait_idle();
		if (!timed_out) begin
			char_in    = c;
			char_valid = 1'b1;
			@(posedge clk);
			#1;
			char_valid = 1'b0;
			wait_idle();
		end
	endtask

	task automatic expect_pulse(input logic rs_exp, input logic [7:0] data_exp);
		lcd_pkg::lcd_cmd_t cap;
		if (captures.size() == 0) begin
			$display("missing enable pulse: expected data %h with rs %0d", data_exp, rs_exp);
			errors++;
		end else begin
			cap = captures.pop_front();
			check("rs", 32'(cap.rs), 32'(rs_exp));
			check("rw", 32'(cap.rw), 32'd0);
			check("lcd_data", 32'(cap.data), 32'(data_exp));
		end
	endtask

	task automatic finish_test();
		if (test_open) begin
			if (captures.size() != 0) begin
				$display("%0d enable pulses arrived that were not expected", captures.size());
				errors++;
				captures.delete();
			end
			tests++;
			if (errors == test_start) begin
				$display("test %0s: ok", name);
			end else begin
				$display("test %0s: %0d errors", name, errors - test_start);
				failed_tests++;
			end
		end
	endtask

	initial begin
		int            fd;
		int            r;
		int            count;
		reg [7:0]      tag;
		reg [7:0]      word;
		reg [7:0]      data_now;
		reg            rs_exp;
		reg [8*80-1:0] text;
		rst          = 1'b1;
		cfg          = '0;
		char_in      = 8'h00;
		char_valid   = 1'b0;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		test_open    = 1'b0;
		timed_out    = 1'b0;
		fd = $fopen("bench/lcd_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file bench/lcd_trace.txt");
			errors++;
		end else begin
			while (!timed_out && $fscanf(fd, " %c", tag) == 1) begin
				case (tag)
					"#": r = $fgets(text, fd);
					"T": begin
						finish_test();
						r = $fscanf(fd, " %s", name);
						test_open  = 1'b1;
						test_start = errors;
					end
					"F": begin
						r = $fscanf(fd, " %h", word);
						apply_reset(word[6:0]);
					end
					"C": begin
						r = $fscanf(fd, " %h %d", data_now, count);
						for (int i = 0; i < count && !timed_out; i++) begin
							send_char(data_now);
							data_now = data_now + 8'd1;
						end
					end
					"E": begin
						r = $fscanf(fd, " %h %h %d", rs_exp, data_now, count);
						for (int i = 0; i < count; i++) begin
							expect_pulse(rs_exp, data_now);
							data_now = data_now + 8'd1;
						end
					end
					default: begin
						$display("unknown line tag %c in the trace file", tag);
						errors++;
					end
				endcase
			end
			finish_test();
			$fclose(fd);
		end
		$display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
		if (errors == 0 && !timed_out) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/lcd_trace.txt ====
# T name | F cfg_word | C first_char count | E rs first_data count
# C and E step the byte by one per repeat
T init
F 5A
E 0 38 1
E 0 0E 1
E 0 01 1
E 0 06 1
T print
C 41 16
E 1 41 16
T wrap
C 51 1
E 0 C0 1
E 1 51 1
C 52 15
E 1 52 15
C 61 1
E 0 80 1
E 1 61 1
T newline
C 0A 1
E 0 C0 1
C 0A 1
E 0 80 1
C 62 1
E 1 62 1
T clear
C 0C 1
E 0 01 1
C 63 16
E 1 63 16
C 73 1
E 0 C0 1
E 1 73 1

// ==== all.f ====
common/lcd_pkg.sv
lcd_driver/lcd_driver.sv
source/text_formatter.sv
source/lcd_top.sv
bench/lcd_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the LCD testbench with Verilator
verilator --binary -f all.f --top-module lcd_tb -o lcd_sim > build.log 2>&1 &&
./obj_dir/lcd_sim > sim.log 2>&1 ||
{ echo "build or simulation run failed"; exit 1; }
grep -q "TESTS PASSED" sim.log && echo "simulation ok" ||
{ echo "simulation reported failure, see sim.log"; exit 1; }
